// File: rtl/udp_echo_pkg.sv
//----------------------------------------------------------------------------
// Shared types for the UDP echo subsystem: header structs, payload beat
// and the constants that the echo rule depends on
//----------------------------------------------------------------------------

package udp_echo_pkg;

    // Addresses of a received IP datagram
    typedef struct packed {
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
    } ip_rx_hdr_t;

    // UDP header in network order, source_port is sent first
    typedef struct packed {
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_fields_t;

    // Byte 7 holds the first header byte received on the wire
    typedef union packed {
        udp_fields_t     fields;
        logic [7:0][7:0] bytes;
    } udp_hdr_word_u;

    typedef struct packed {
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
        udp_fields_t udp;
    } udp_rx_hdr_t;

    typedef struct packed {
        logic [5:0]  ip_dscp;
        logic [1:0]  ip_ecn;
        logic [7:0]  ip_ttl;
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_tx_hdr_t;

    // One byte of a payload stream
    typedef struct packed {
        logic [7:0] tdata;
        logic       tlast;
        logic       tuser;
    } axis_byte_t;

    localparam logic [7:0] ECHO_TTL = 8'd64;  // TTL written into every echo header

endpackage

// File: rtl/udp_rx_parser.sv
//----------------------------------------------------------------------------
// Splits a received IP datagram into a UDP header and a payload stream.
// The first eight payload bytes form the header, the rest go to the FIFO
//----------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module udp_rx_parser
    import udp_echo_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  ip_rx_hdr_t  ip_hdr,
    input  logic        ip_hdr_valid,
    output logic        ip_hdr_ready,

    input  axis_byte_t  ip_payload,
    input  logic        ip_payload_valid,
    output logic        ip_payload_ready,

    output udp_rx_hdr_t rx_hdr,
    output logic        rx_hdr_valid,
    input  logic        rx_hdr_ready,

    output axis_byte_t  fifo_in,
    output logic        fifo_in_valid,
    input  logic        fifo_in_ready
);
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_HDR     = 2'd1;
    localparam logic [1:0] ST_PAYLOAD = 2'd2;

    logic [1:0]    state;
    logic [2:0]    byte_cnt;
    logic          hdr_pending;  // Header waits for the loopback
    logic          last_done;    // The tlast beat went to the FIFO
    ip_rx_hdr_t    ip_addr;
    udp_hdr_word_u hdr_word;

    logic payload_fire;
    logic hdr_taken;
    logic tail_taken;

    assign payload_fire = ip_payload_valid && ip_payload_ready;
    assign hdr_taken    = !hdr_pending || rx_hdr_ready;
    assign tail_taken   = last_done || (payload_fire && ip_payload.tlast);

    //------------------------------------------------------------------------
    // Handshake outputs
    //------------------------------------------------------------------------
    always_comb begin
        ip_hdr_ready     = (state == ST_IDLE);
        ip_payload_ready = 1'b0;
        fifo_in_valid    = 1'b0;
        case (state)
            ST_HDR: ip_payload_ready = 1'b1;
            ST_PAYLOAD: begin
                fifo_in_valid    = ip_payload_valid && !last_done;
                ip_payload_ready = fifo_in_ready && !last_done;
            end
            default: ;
        endcase
    end

    assign fifo_in      = ip_payload;
    assign rx_hdr_valid = hdr_pending;
    assign rx_hdr       = {ip_addr.ip_source_ip, ip_addr.ip_dest_ip, hdr_word.fields};

    //------------------------------------------------------------------------
    // Control state
    //------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            byte_cnt    <= '0;
            hdr_pending <= 1'b0;
            last_done   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ip_hdr_valid) begin
                        state    <= ST_HDR;
                        byte_cnt <= '0;
                    end
                end
                ST_HDR: begin
                    if (payload_fire) begin
                        byte_cnt <= byte_cnt + 3'd1;
                        if (byte_cnt == 3'd7) begin  // Eighth header byte
                            state       <= ST_PAYLOAD;
                            hdr_pending <= 1'b1;
                            last_done   <= 1'b0;
                        end
                    end
                end
                ST_PAYLOAD: begin
                    if (rx_hdr_valid && rx_hdr_ready) hdr_pending <= 1'b0;
                    if (payload_fire && ip_payload.tlast) last_done <= 1'b1;
                    // Header and tail may finish in either order
                    if (hdr_taken && tail_taken) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address capture and header byte shifter
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && ip_hdr_valid) ip_addr <= ip_hdr;
        if (state == ST_HDR && payload_fire) begin
            hdr_word.bytes <= {hdr_word.bytes[6:0], ip_payload.tdata};
        end
    end

endmodule

`default_nettype wire

// File: rtl/udp_payload_fifo.sv
//----------------------------------------------------------------------------
// Payload beat FIFO between parser and loopback. Lets the parser start on
// the next datagram while the current one drains
//----------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module udp_payload_fifo
    import udp_echo_pkg::*;
#(
    parameter int FIFO_DEPTH = 16  // Power of two
) (
    input  logic       clk,
    input  logic       reset,

    input  axis_byte_t in_data,
    input  logic       in_valid,
    output logic       in_ready,

    output axis_byte_t out_data,
    output logic       out_valid,
    input  logic       out_ready
);
    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    axis_byte_t      mem [FIFO_DEPTH];
    logic [ADDR_W:0] wr_ptr;  // Top bit tells a full buffer from an empty one
    logic [ADDR_W:0] rd_ptr;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr[ADDR_W-1:0]];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr[ADDR_W-1:0]] <= in_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/udp_loopback.sv
//----------------------------------------------------------------------------
// Echoes UDP datagrams addressed to UDP_PORT back to their sender and
// drains the payload of all other datagrams
//----------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module udp_loopback
    import udp_echo_pkg::*;
#(
    parameter bit [15:0] UDP_PORT = 16'd1234
) (
    input  logic        clk,
    input  logic        reset,

    input  logic [31:0] local_ip,

    input  udp_rx_hdr_t rx_hdr,
    input  logic        rx_hdr_valid,
    output logic        rx_hdr_ready,

    output udp_tx_hdr_t tx_hdr,
    output logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,

    input  axis_byte_t  fifo_out,
    input  logic        fifo_out_valid,
    output logic        fifo_out_ready,

    output axis_byte_t  tx_payload,
    output logic        tx_payload_valid,
    input  logic        tx_payload_ready
);
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_FWD  = 2'd1;
    localparam logic [1:0] ST_DROP = 2'd2;

    logic [1:0] state;
    logic       match;
    logic       idle;

    assign match = (rx_hdr.udp.dest_port == UDP_PORT);
    assign idle  = (state == ST_IDLE);

    // A foreign header is swallowed at once, an echo waits for the sink
    assign tx_hdr_valid = idle && rx_hdr_valid && match;
    assign rx_hdr_ready = idle && (match ? tx_hdr_ready : 1'b1);

    always_comb begin
        tx_hdr.ip_dscp      = '0;
        tx_hdr.ip_ecn       = '0;
        tx_hdr.ip_ttl       = ECHO_TTL;
        tx_hdr.ip_source_ip = local_ip;
        tx_hdr.ip_dest_ip   = rx_hdr.ip_source_ip;
        tx_hdr.source_port  = rx_hdr.udp.dest_port;
        tx_hdr.dest_port    = rx_hdr.udp.source_port;
        tx_hdr.length       = rx_hdr.udp.length;
        tx_hdr.checksum     = '0;
    end

    //------------------------------------------------------------------------
    // Payload path
    //------------------------------------------------------------------------
    assign tx_payload       = fifo_out;
    assign tx_payload_valid = (state == ST_FWD) && fifo_out_valid;
    assign fifo_out_ready   = (state == ST_DROP) || ((state == ST_FWD) && tx_payload_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rx_hdr_valid && rx_hdr_ready) state <= match ? ST_FWD : ST_DROP;
                end
                ST_FWD, ST_DROP: begin
                    // The datagram ends with its tlast beat
                    if (fifo_out_valid && fifo_out_ready && fifo_out.tlast) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/udp_echo_top.sv
//----------------------------------------------------------------------------
// UDP echo subsystem: parser, payload FIFO and loopback in a chain.
// Set UDP_PORT and FIFO_DEPTH here
//----------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module udp_echo_top
    import udp_echo_pkg::*;
#(
    parameter bit [15:0] UDP_PORT   = 16'd1234,
    parameter int        FIFO_DEPTH = 16
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] local_ip,

    input  ip_rx_hdr_t  ip_hdr,
    input  logic        ip_hdr_valid,
    output logic        ip_hdr_ready,
    input  axis_byte_t  ip_payload,
    input  logic        ip_payload_valid,
    output logic        ip_payload_ready,

    output udp_tx_hdr_t tx_hdr,
    output logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,
    output axis_byte_t  tx_payload,
    output logic        tx_payload_valid,
    input  logic        tx_payload_ready
);
    udp_rx_hdr_t rx_hdr;
    logic        rx_hdr_valid;
    logic        rx_hdr_ready;
    axis_byte_t  fifo_in;
    logic        fifo_in_valid;
    logic        fifo_in_ready;
    axis_byte_t  fifo_out;
    logic        fifo_out_valid;
    logic        fifo_out_ready;

    udp_rx_parser u_parser (
        .clk              (clk),
        .reset            (reset),
        .ip_hdr           (ip_hdr),
        .ip_hdr_valid     (ip_hdr_valid),
        .ip_hdr_ready     (ip_hdr_ready),
        .ip_payload       (ip_payload),
        .ip_payload_valid (ip_payload_valid),
        .ip_payload_ready (ip_payload_ready),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .fifo_in          (fifo_in),
        .fifo_in_valid    (fifo_in_valid),
        .fifo_in_ready    (fifo_in_ready)
    );

    udp_payload_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_data   (fifo_in),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_data  (fifo_out),
        .out_valid (fifo_out_valid),
        .out_ready (fifo_out_ready)
    );

    udp_loopback #(.UDP_PORT(UDP_PORT)) u_loopback (
        .clk              (clk),
        .reset            (reset),
        .local_ip         (local_ip),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .fifo_out         (fifo_out),
        .fifo_out_valid   (fifo_out_valid),
        .fifo_out_ready   (fifo_out_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
//----------------------------------------------------------------------------
// Free running testbench clock, period set by PERIOD in ns
//----------------------------------------------------------------------------

`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic clk
);
    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: tests/udp_echo_asserts.sv
//----------------------------------------------------------------------------
// Handshake checks on the echo outputs, bound into every udp_echo_top
//----------------------------------------------------------------------------

`timescale 1ns/1ns

module udp_echo_asserts
    import udp_echo_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input udp_tx_hdr_t tx_hdr,
    input logic        tx_hdr_valid,
    input logic        tx_hdr_ready,
    input axis_byte_t  tx_payload,
    input logic        tx_payload_valid,
    input logic        tx_payload_ready
);
    int   assert_errors = 0;
    logic hdr_seen;  // An echo header went out since the last tlast

    always_ff @(posedge clk) begin
        if (reset) begin
            hdr_seen <= 1'b0;
        end else if (tx_hdr_valid && tx_hdr_ready) begin
            hdr_seen <= 1'b1;
        end else if (tx_payload_valid && tx_payload_ready && tx_payload.tlast) begin
            hdr_seen <= 1'b0;
        end
    end

    hdr_held: assert property (@(posedge clk) disable iff (reset)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
        else begin $error("tx_hdr dropped or changed while stalled"); assert_errors++; end

    beat_held: assert property (@(posedge clk) disable iff (reset)
        tx_payload_valid && !tx_payload_ready |=> tx_payload_valid && $stable(tx_payload))
        else begin $error("tx_payload dropped or changed while stalled"); assert_errors++; end

    // Outputs are quiet in the cycle after any reset cycle
    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !tx_hdr_valid && !tx_payload_valid)
        else begin $error("output valid high right after reset"); assert_errors++; end

    payload_after_hdr: assert property (@(posedge clk) disable iff (reset)
        tx_payload_valid |-> hdr_seen)
        else begin $error("payload beat without an echo header"); assert_errors++; end

endmodule

bind udp_echo_top udp_echo_asserts u_asserts (.*);

// File: tests/udp_echo_tb.sv
//----------------------------------------------------------------------------
// Directed testbench for udp_echo_top. Each test sends datagrams and
// compares the echoed headers and payload with the echo rule
//----------------------------------------------------------------------------

`timescale 1ns/1ns

module udp_echo_tb
    import udp_echo_pkg::*;
;
    localparam bit [15:0]   UDP_PORT = 16'd1234;
    localparam logic [31:0] LOCAL_IP = 32'hc0a8_0164;

    logic clk, reset, ip_hdr_valid, ip_hdr_ready, ip_payload_valid, ip_payload_ready;
    logic tx_hdr_valid, tx_hdr_ready, tx_payload_valid, tx_payload_ready;
    logic [31:0] local_ip;
    ip_rx_hdr_t  ip_hdr;
    axis_byte_t  ip_payload, tx_payload;
    udp_tx_hdr_t tx_hdr;

    integer      seed = 32'h3d0b_03a4;
    int          budget_cycles = 0;  // Grows with every byte sent
    logic        bp_on = 1'b0;
    logic        bp_now;
    logic [31:0] rdy_rnd;

    ip_rx_hdr_t  cur_ip;
    udp_fields_t cur_udp;
    axis_byte_t  cur_bytes[$];
    udp_tx_hdr_t exp_hdrs[$], rx_hdrs[$];
    axis_byte_t  exp_beats[$], rx_beats[$];

    tb_clock #(.PERIOD(4)) u_clock (.clk(clk));

    udp_echo_top #(.UDP_PORT(UDP_PORT), .FIFO_DEPTH(16)) DUT (.*);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic compare_tx_hdr(input string name, input udp_tx_hdr_t exp,
                                  input udp_tx_hdr_t got);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t ns: %s expected %h, got %h",
                               $time, name, exp, got));
    endtask

    task automatic compare_beat(input string name, input axis_byte_t exp,
                                input axis_byte_t got);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t ns: %s expected %h, got %h",
                               $time, name, exp, got));
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic got);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t ns: %s expected %b, got %b",
                               $time, name, exp, got));
    endtask

    // Addresses and ports swap, length is kept, the rest is fixed
    function automatic udp_tx_hdr_t expected_echo(input ip_rx_hdr_t ip, input udp_fields_t u);
        udp_tx_hdr_t h;
        h.ip_dscp      = '0;
        h.ip_ecn       = '0;
        h.ip_ttl       = ECHO_TTL;
        h.ip_source_ip = LOCAL_IP;
        h.ip_dest_ip   = ip.ip_source_ip;
        h.source_port  = u.dest_port;
        h.dest_port    = u.source_port;
        h.length       = u.length;
        h.checksum     = '0;
        return h;
    endfunction

    // Output sinks sample transfers at the falling edge, where all is settled
    always @(negedge clk) begin
        if (!reset && tx_hdr_valid && tx_hdr_ready) rx_hdrs.push_back(tx_hdr);
        if (!reset && tx_payload_valid && tx_payload_ready) rx_beats.push_back(tx_payload);
    end

    // The ready pattern is drawn on the edge itself, away from the stimulus draws
    always @(posedge clk) begin
        bp_now = bp_on;
        if (bp_now) rdy_rnd = $random(seed);
        #1;
        if (bp_now) begin
            tx_hdr_ready     = rdy_rnd[1:0] != 2'd0;
            tx_payload_ready = rdy_rnd[6:4] < 3'd3;  // Slow sink so the FIFO fills up
        end else begin
            tx_hdr_ready     = 1'b1;
            tx_payload_ready = 1'b1;
        end
    end

    task automatic apply_reset();
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    task automatic build_datagram(input logic [15:0] dport, input int len);
        logic [31:0] rnd;
        axis_byte_t  beat;
        rnd = $random(seed);
        cur_ip.ip_source_ip = $random(seed);
        cur_ip.ip_dest_ip   = LOCAL_IP;
        cur_udp.source_port = rnd[15:0];
        cur_udp.dest_port   = dport;
        cur_udp.length      = 16'(len + 8);
        cur_udp.checksum    = rnd[31:16];
        cur_bytes.delete();
        for (int k = 0; k < 8; k++) cur_bytes.push_back({cur_udp[63 - 8*k -: 8], 2'b00});
        for (int k = 0; k < len; k++) begin
            rnd = $random(seed);
            beat.tdata = rnd[7:0];
            beat.tlast = (k == len - 1);
            beat.tuser = rnd[8];
            cur_bytes.push_back(beat);
            if (dport == UDP_PORT) exp_beats.push_back(beat);
        end
        if (dport == UDP_PORT) exp_hdrs.push_back(expected_echo(cur_ip, cur_udp));
        budget_cycles += (len + 8) * 20;
    endtask

    // Runs from just after a rising edge; stops after stop_after bytes
    task automatic drive_datagram(input int stop_after);
        logic ok;
        ip_hdr       = cur_ip;
        ip_hdr_valid = 1'b1;
        do begin
            @(negedge clk);
            ok = ip_hdr_ready;
            @(posedge clk);
            #1;
        end while (!ok);
        ip_hdr_valid = 1'b0;
        for (int i = 0; i < cur_bytes.size() && i < stop_after; i++) begin
            ip_payload       = cur_bytes[i];
            ip_payload_valid = 1'b1;
            do begin
                @(negedge clk);
                ok = ip_payload_ready;
                @(posedge clk);
                #1;
            end while (!ok);
        end
        ip_payload_valid = 1'b0;
    endtask

    task automatic send_datagram(input logic [15:0] dport, input int len);
        build_datagram(dport, len);
        drive_datagram(len + 8);
    endtask

    task automatic check_outputs();
        while (rx_hdrs.size() < exp_hdrs.size() || rx_beats.size() < exp_beats.size())
            @(posedge clk);
        repeat (10) @(posedge clk);  // Room for any output that should not be there
        #1;
        if (rx_hdrs.size() != exp_hdrs.size())
            fail_run($sformatf("expected %0d echo headers but saw %0d",
                               exp_hdrs.size(), rx_hdrs.size()));
        if (rx_beats.size() != exp_beats.size())
            fail_run($sformatf("expected %0d echo payload beats but saw %0d",
                               exp_beats.size(), rx_beats.size()));
        foreach (exp_hdrs[i]) compare_tx_hdr($sformatf("tx_hdr[%0d]", i), exp_hdrs[i], rx_hdrs[i]);
        foreach (exp_beats[i])
            compare_beat($sformatf("tx_payload[%0d]", i), exp_beats[i], rx_beats[i]);
        exp_hdrs.delete();
        rx_hdrs.delete();
        exp_beats.delete();
        rx_beats.delete();
    endtask

    //------------------------------------------------------------------------
    // Tests
    //------------------------------------------------------------------------
    task automatic test_match_echo();
        send_datagram(UDP_PORT, 10);
        check_outputs();
    endtask

    task automatic test_drop_then_match();
        send_datagram(16'd4321, 20);  // Longer than the FIFO, all of it drained
        send_datagram(UDP_PORT, 5);
        check_outputs();
    endtask

    task automatic test_backpressure();
        build_datagram(UDP_PORT, 40);
        bp_on = 1'b1;
        drive_datagram(48);
        check_outputs();
        bp_on = 1'b0;
    endtask

    task automatic test_mixed_stream();
        logic [31:0] rnd;
        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            send_datagram(rnd[0] ? UDP_PORT : UDP_PORT + 16'(i + 1), 1 + int'(rnd[12:8]) % 24);
        end
        check_outputs();
    endtask

    task automatic test_reset_recovery();
        build_datagram(UDP_PORT, 12);
        drive_datagram(14);
        apply_reset();
        exp_hdrs.delete();
        rx_hdrs.delete();
        exp_beats.delete();
        rx_beats.delete();
        compare_flag("tx_hdr_valid", 1'b0, tx_hdr_valid);
        compare_flag("tx_payload_valid", 1'b0, tx_payload_valid);
        compare_flag("ip_hdr_ready", 1'b1, ip_hdr_ready);
        send_datagram(UDP_PORT, 7);
        check_outputs();
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= budget_cycles + 500) begin
            @(posedge clk);
            cycles++;
        end
        fail_run("timeout: the echo output did not finish within the cycle budget");
    end

    // A handshake assertion that fires ends the run at once
    initial begin : assert_watch
        wait (DUT.u_asserts.assert_errors != 0);
        fail_run("a handshake assertion on the echo outputs failed");
    end

    initial begin
        reset            = 1'b1;
        local_ip         = LOCAL_IP;
        ip_hdr           = '0;
        ip_hdr_valid     = 1'b0;
        ip_payload       = '0;
        ip_payload_valid = 1'b0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        apply_reset();
        test_match_echo();
        test_drop_then_match();
        test_backpressure();
        test_mixed_stream();
        test_reset_recovery();
        if (DUT.u_asserts.assert_errors == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_run("a handshake assertion on the echo outputs failed");
        end
    end

endmodule

// File: filelist.f
rtl/udp_echo_pkg.sv
rtl/udp_rx_parser.sv
rtl/udp_payload_fifo.sv
rtl/udp_loopback.sv
rtl/udp_echo_top.sv
tests/tb_clock.sv
tests/udp_echo_asserts.sv
tests/udp_echo_tb.sv

// File: Bender.yml
package:
  name: udp_echo

sources:
  - files:
      - rtl/udp_echo_pkg.sv
      - rtl/udp_rx_parser.sv
      - rtl/udp_payload_fifo.sv
      - rtl/udp_loopback.sv
      - rtl/udp_echo_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/udp_echo_asserts.sv
      - tests/udp_echo_tb.sv
